//--- all.f
hw/fetch_pkg.sv
hw/fetch_pc_gen.sv
hw/fetch_noicache.sv
hw/fetch_biu_axil.sv
hw/fetch_top.sv
sim/fetch_assert.sv
sim/fetch_tb.sv

//--- run.sh
#!/bin/sh
# build with Verilator and run; status follows the testbench result
cd "$(dirname "$0")" || exit 1
verilator --binary --timing --assert -j 0 --top-module fetch_tb -f all.f -o fetch_sim \
  || { echo "build failed"; exit 1; }
out=$(obj_dir/fetch_sim)
echo "$out"
echo "$out" | grep -qx "Testbench passed" && exit 0 || exit 1

//--- sim/fetch_tb.sv
`timescale 1ns/10ps
`default_nettype none

module fetch_tb import fetch_pkg::*; ();

  ////////////////////////////////////////////////////////////
  // DUT signals, all inputs start defined
  ////////////////////////////////////////////////////////////

  logic      clk = 1'b0;
  logic      rstn = 1'b0;
  redirect_t redirect = '0;
  logic      stall = 1'b0;
  logic      dc_flush_rdy = 1'b0;
  prv_e      st_prv = PRV_M;
  parcel_t   parcel;
  axil_ar_t  ar;
  logic      arready = 1'b0;
  axil_r_t   r = '0;
  logic      rready;

  // mode flags, owned by the test sequence
  logic        run = 1'b0;
  logic        rand_en = 1'b0;
  logic        stall_en = 1'b0;
  logic        dcr_en = 1'b0;
  logic        redir_en = 1'b0;
  logic        mis_en = 1'b0;
  logic        err_en = 1'b0;
  logic        idle_chk = 1'b0;
  logic        timed_out = 1'b0;
  int          dir_seq = 0;
  logic [31:0] dir_target = '0;

  // model state, owned by the clocked model
  logic [31:0] lfsr = 32'hb4ca6444;
  logic [31:0] exp_pc = RESET_PC;
  logic [31:0] mem_q [$];
  logic        rstn_q = 1'b0;
  int          dly = 0;
  int          dir_done = 0;
  int          errors = 0;
  int          checks = 0;
  int          parcels = 0;
  int          hs_cnt = 0;
  int          ntests = 0;

  fetch_top UUT (
    .clk          (clk),
    .rstn         (rstn),
    .redirect     (redirect),
    .stall        (stall),
    .dc_flush_rdy (dc_flush_rdy),
    .st_prv       (st_prv),
    .parcel       (parcel),
    .ar           (ar),
    .arready      (arready),
    .r            (r),
    .rready       (rready)
  );

  initial begin
    forever #4 clk = ~clk;
  end

  ////////////////////////////////////////////////////////////
  // helpers
  ////////////////////////////////////////////////////////////

  // galois lfsr, one step per bit taken
  function automatic logic [31:0] rand_bits(input int n);
    logic [31:0] v;
    v = '0;
    for (int i = 0; i < n; i++) begin
      v    = {v[30:0], lfsr[0]};
      lfsr = (lfsr >> 1) ^ (lfsr[0] ? 32'hd000_0001 : 32'h0);
    end
    return v;
  endfunction

  // memory data rule: xor then rotate left by 3
  function automatic logic [31:0] mem_word(input logic [31:0] a);
    logic [31:0] x;
    x = a ^ 32'h5a5a_0000;
    return {x[28:0], x[31:29]};
  endfunction

  task automatic check_val(input string name, input logic [31:0] got, input logic [31:0] exp);
    checks++;
    if (got !== exp) begin
      errors++;
      $display("CHECK FAILED %s: got %h expected %h", name, got, exp);
    end
  endtask

  ////////////////////////////////////////////////////////////
  // memory model, reference model and random drive
  ////////////////////////////////////////////////////////////

  always @(posedge clk) begin
    logic [31:0] tgt;
    logic [31:0] word;
    // reset and the cycle after it are quiet
    if (!rstn || !rstn_q) begin
      check_val("ar.arvalid", 32'(ar.arvalid), 32'h0);
      check_val("parcel.valid", 32'(parcel.valid), 32'h0);
    end
    rstn_q = rstn;
    if (rstn) begin
      // read data accepted, fetch must always be ready
      if (r.rvalid) begin
        check_val("rready", 32'(rready), 32'h1);
        void'(mem_q.pop_front());
      end
      if (ar.arvalid && arready) begin
        hs_cnt++;
        mem_q.push_back(ar.araddr);
        if (idle_chk) begin
          errors++;
          $display("AR handshake seen while dc_flush_rdy was held low");
        end
        // instruction bit, privileged bit from st_prv
        check_val("ar.arprot", 32'(ar.arprot), {29'b0, 1'b1, 1'b0, st_prv != PRV_U});
      end
      // in-order responses after a random gap
      if (dly != 0) begin
        dly--;
      end
      if (mem_q.size() != 0 && dly == 0) begin
        r.rvalid <= 1'b1;
        r.rdata  <= mem_word(mem_q[0]);
        r.rresp  <= (err_en && mem_q[0][5:2] == 4'hf) ? RESP_SLVERR : RESP_OKAY;
        dly = rand_en ? int'(rand_bits(2)) + 1 : 1;
      end else begin
        r.rvalid <= 1'b0;
      end

      // parcel against the expected pc
      if (parcel.valid) begin
        parcels++;
        if (stall) begin
          errors++;
          $display("parcel presented while stall was high");
        end
        word = {exp_pc[31:2], 2'b00};
        check_val("parcel.pc", parcel.pc, exp_pc);
        check_val("parcel.insn", parcel.insn, mem_word(word));
        check_val("parcel.misaligned", 32'(parcel.misaligned), 32'(|exp_pc[1:0]));
        check_val("parcel.err", 32'(parcel.err), 32'(err_en && exp_pc[5:2] == 4'hf));
        exp_pc = exp_pc + 32'd4;
      end
      // old path ends with the redirect
      if (redirect.valid) begin
        exp_pc = redirect.target;
      end

      // next inputs
      if (rand_en) begin
        arready <= rand_bits(1) != 0;
      end else begin
        arready <= 1'b1;
      end
      if (stall_en) begin
        stall <= rand_bits(2) == 0;
      end else begin
        stall <= 1'b0;
      end
      if (!run) begin
        dc_flush_rdy <= 1'b0;
      end else if (dcr_en) begin
        dc_flush_rdy <= rand_bits(3) != 0;
      end else begin
        dc_flush_rdy <= 1'b1;
      end
      if (dir_seq != dir_done) begin
        redirect.valid  <= 1'b1;
        redirect.target <= dir_target;
        dir_done = dir_seq;
      end else if (redir_en && !redirect.valid && rand_bits(5) == 0) begin
        tgt = 32'h0000_1000 + (rand_bits(12) << 2);
        if (mis_en) begin
          tgt = tgt | rand_bits(2);
        end
        redirect.valid  <= 1'b1;
        redirect.target <= tgt;
      end else begin
        redirect.valid <= 1'b0;
      end
    end
  end

  ////////////////////////////////////////////////////////////
  // test sequence
  ////////////////////////////////////////////////////////////

  // stop issuing and let the bus and queue drain
  task automatic quiesce();
    int t;
    int idle;
    t = 0;
    idle = 0;
    @(posedge clk);
    run      <= 1'b0;
    rand_en  <= 1'b0;
    stall_en <= 1'b0;
    dcr_en   <= 1'b0;
    redir_en <= 1'b0;
    mis_en   <= 1'b0;
    while (!(mem_q.size() == 0 && !r.rvalid && !ar.arvalid && idle >= 4) && t < 500) begin
      @(posedge clk);
      idle = parcel.valid ? 0 : idle + 1;
      t++;
    end
    if (t >= 500) begin
      $display("timeout while draining the fetch pipeline");
      timed_out = 1'b1;
    end
  endtask

  task automatic run_phase(input string name, input int n);
    int base;
    int err0;
    int t;
    base = parcels;
    err0 = errors;
    t = 0;
    // later tests are skipped once a wait gave up
    if (timed_out) begin
      return;
    end
    while (parcels < base + n && t < 20000) begin
      @(posedge clk);
      t++;
    end
    if (parcels < base + n) begin
      $display("timeout waiting for parcels in test %s", name);
      timed_out = 1'b1;
    end else begin
      quiesce();
      if (!timed_out) begin
        ntests++;
        $display("test %s: %0d parcels, %0d errors", name, parcels - base, errors - err0);
      end
    end
  endtask

  initial begin
    int err0;
    // reset held 4 cycles, dc_flush_rdy low throughout test 1
    repeat (4) @(posedge clk);
    rstn     <= 1'b1;
    idle_chk <= 1'b1;
    err0 = errors;
    repeat (12) @(posedge clk);
    idle_chk <= 1'b0;
    ntests++;
    $display("test reset_idle: %0d handshakes, %0d errors", hs_cnt, errors - err0);

    // plain stream, machine mode
    @(posedge clk);
    run     <= 1'b1;
    rand_en <= 1'b1;
    run_phase("seq_stream", 200);

    // stall and dcache gate, user mode
    st_prv   <= PRV_U;
    run      <= 1'b1;
    rand_en  <= 1'b1;
    stall_en <= 1'b1;
    dcr_en   <= 1'b1;
    run_phase("stall", 200);

    // random redirects, supervisor mode
    st_prv   <= PRV_S;
    run      <= 1'b1;
    rand_en  <= 1'b1;
    stall_en <= 1'b1;
    redir_en <= 1'b1;
    run_phase("redirect", 300);

    // 0x203e hits both misaligned and the slverr window
    st_prv     <= PRV_M;
    err_en     <= 1'b1;
    run        <= 1'b1;
    rand_en    <= 1'b1;
    redir_en   <= 1'b1;
    mis_en     <= 1'b1;
    dir_target <= 32'h0000_203e;
    dir_seq    <= dir_seq + 1;
    run_phase("misaligned_err", 300);
    @(posedge clk);
    err_en <= 1'b0;

    // arprot under user mode with no stalls
    st_prv  <= PRV_U;
    run     <= 1'b1;
    rand_en <= 1'b1;
    run_phase("arprot", 100);

    $display("tests %0d, checks %0d, errors %0d", ntests, checks, errors);
    if (errors == 0 && !timed_out) begin
      $display("Testbench passed");
    end else begin
      $display("Testbench failed");
    end
    $finish;
  end

endmodule

`default_nettype wire

//--- sim/fetch_assert.sv
`timescale 1ns/10ps
`default_nettype none

module fetch_assert import fetch_pkg::*; (
  input logic     clk,
  input logic     rstn,
  input axil_ar_t ar,
  input logic     arready,
  input axil_r_t  r,
  input logic     rready,
  input parcel_t  parcel,
  input logic     stall
);

  ////////////////////////////////////////////////////////////
  // reads on the bus, counted from the handshakes
  ////////////////////////////////////////////////////////////

  logic [2:0] outstanding;

  always_ff @(posedge clk or negedge rstn) begin
    if (!rstn) begin
      outstanding <= 3'd0;
    end else begin
      outstanding <= outstanding + {2'b0, ar.arvalid & arready} - {2'b0, r.rvalid & rready};
    end
  end

  // address held until accepted
  ar_stable: assert property (@(posedge clk) disable iff (!rstn)
    ar.arvalid && !arready |=> ar.arvalid && $stable(ar.araddr))
    else $error("araddr or arvalid changed before arready");

  no_parcel_on_stall: assert property (@(posedge clk) disable iff (!rstn)
    stall |-> !parcel.valid)
    else $error("parcel valid during stall");

  max_outstanding: assert property (@(posedge clk) disable iff (!rstn)
    outstanding <= 3'(MAX_OUTSTANDING))
    else $error("too many reads in flight");

endmodule

bind fetch_top fetch_assert u_assert (
  .clk     (clk),
  .rstn    (rstn),
  .ar      (ar),
  .arready (arready),
  .r       (r),
  .rready  (rready),
  .parcel  (parcel),
  .stall   (stall)
);

`default_nettype wire

//--- hw/fetch_top.sv
`timescale 1ns/10ps
`default_nettype none

module fetch_top import fetch_pkg::*; (
  input  logic      clk,
  input  logic      rstn,
  // core side
  input  redirect_t redirect,
  input  logic      stall,
  input  logic      dc_flush_rdy,
  input  prv_e      st_prv,
  output parcel_t   parcel,
  // AXI4-Lite read master
  output axil_ar_t  ar,
  input  logic      arready,
  input  axil_r_t   r,
  output logic      rready
);

  // pc generator to fetch unit
  logic [XLEN-1:0] nxt_pc;
  logic            flush;
  logic            stall_nxt_pc;

  // fetch unit to BIU
  biu_req_t        biu_req;
  logic            stb_ack;
  biu_rsp_t        biu_rsp;

  fetch_pc_gen u_pc_gen (
    .clk          (clk),
    .rstn         (rstn),
    .redirect     (redirect),
    .stall_nxt_pc (stall_nxt_pc),
    .nxt_pc       (nxt_pc),
    .flush        (flush)
  );

  fetch_noicache u_fetch (
    .clk          (clk),
    .rstn         (rstn),
    .nxt_pc       (nxt_pc),
    .flush        (flush),
    .stall_nxt_pc (stall_nxt_pc),
    .stall        (stall),
    .dc_flush_rdy (dc_flush_rdy),
    .st_prv       (st_prv),
    .parcel       (parcel),
    .biu_req      (biu_req),
    .stb_ack      (stb_ack),
    .biu_rsp      (biu_rsp)
  );

  // flush also reaches the BIU to kill reads on the bus
  fetch_biu_axil u_biu (
    .clk     (clk),
    .rstn    (rstn),
    .flush   (flush),
    .biu_req (biu_req),
    .stb_ack (stb_ack),
    .biu_rsp (biu_rsp),
    .ar      (ar),
    .arready (arready),
    .r       (r),
    .rready  (rready)
  );

endmodule

`default_nettype wire

//--- hw/fetch_biu_axil.sv
`timescale 1ns/10ps
`default_nettype none

module fetch_biu_axil import fetch_pkg::*; (
  input  logic     clk,
  input  logic     rstn,
  input  logic     flush,
  // fetch unit side
  input  biu_req_t biu_req,
  output logic     stb_ack,
  output biu_rsp_t biu_rsp,
  // AXI4-Lite read channels
  output axil_ar_t ar,
  input  logic     arready,
  input  axil_r_t  r,
  output logic     rready
);

  ////////////////////////////////////////////////////////////
  // declarations
  ////////////////////////////////////////////////////////////

  biu_state_e                 state;
  logic [XLEN-1:0]            ar_addr;
  logic [2:0]                 ar_prot;
  logic                       push;
  logic                       pop;
  // outstanding reads, head at index 0
  logic [1:0]                 oq_cnt;
  logic                       wr_idx;
  logic [MAX_OUTSTANDING-1:0] oq_kill;
  logic [MAX_OUTSTANDING-1:0] kill_nxt;
  logic [XLEN-1:0]            oq_adr [MAX_OUTSTANDING];

  // fetch never back-pressures read data
  assign rready = 1'b1;

  assign stb_ack = (state == BIU_IDLE) && (oq_cnt < 2'(MAX_OUTSTANDING));
  assign push    = biu_req.stb & stb_ack;
  assign pop     = r.rvalid & rready;

  ////////////////////////////////////////////////////////////
  // address channel
  ////////////////////////////////////////////////////////////

  always_ff @(posedge clk or negedge rstn) begin
    if (!rstn) begin
      state <= BIU_IDLE;
    end else begin
      case (state)
        BIU_IDLE: if (push) state <= BIU_AR;
        BIU_AR:   if (arready) state <= BIU_IDLE;
        default:  state <= BIU_IDLE;
      endcase
    end
  end

  // held stable while waiting for arready
  // prot = instruction, secure, privileged unless user mode
  always_ff @(posedge clk) begin
    if (push) begin
      ar_addr <= biu_req.adr;
      ar_prot <= {1'b1, 1'b0, biu_req.prv != PRV_U};
    end
  end

  assign ar.arvalid = (state == BIU_AR);
  assign ar.araddr  = ar_addr;
  assign ar.arprot  = ar_prot;

  ////////////////////////////////////////////////////////////
  // outstanding queue
  ////////////////////////////////////////////////////////////

  // free slot after a same-cycle pop
  assign wr_idx = oq_cnt[1] | (oq_cnt[0] & ~pop);

  // flush kills everything on the bus now
  always_comb begin
    kill_nxt = oq_kill | {MAX_OUTSTANDING{flush}};
    if (pop) begin
      kill_nxt = kill_nxt >> 1;
    end
    if (push) begin
      kill_nxt[wr_idx] = 1'b0;
    end
  end

  always_ff @(posedge clk or negedge rstn) begin
    if (!rstn) begin
      oq_cnt  <= 2'd0;
      oq_kill <= '0;
    end else begin
      oq_cnt  <= oq_cnt + {1'b0, push} - {1'b0, pop};
      oq_kill <= kill_nxt;
    end
  end

  always_ff @(posedge clk) begin
    if (pop) begin
      oq_adr[0] <= oq_adr[1];
    end
    if (push) begin
      oq_adr[wr_idx] <= biu_req.adr;
    end
  end

  ////////////////////////////////////////////////////////////
  // response
  ////////////////////////////////////////////////////////////

  // same cycle pass-through, killed reads are swallowed
  assign biu_rsp.rack = r.rvalid & ~oq_kill[0];
  assign biu_rsp.adr  = oq_adr[0];
  assign biu_rsp.dat  = r.rdata;
  assign biu_rsp.err  = (r.rresp != RESP_OKAY);

endmodule

`default_nettype wire

//--- hw/fetch_noicache.sv
`timescale 1ns/10ps
`default_nettype none

module fetch_noicache import fetch_pkg::*; (
  input  logic            clk,
  input  logic            rstn,
  // pc generator side
  input  logic [XLEN-1:0] nxt_pc,
  input  logic            flush,
  output logic            stall_nxt_pc,
  // core side
  input  logic            stall,
  input  logic            dc_flush_rdy,
  input  prv_e            st_prv,
  output parcel_t         parcel,
  // BIU side
  output biu_req_t        biu_req,
  input  logic            stb_ack,
  input  biu_rsp_t        biu_rsp
);

  ////////////////////////////////////////////////////////////
  // declarations
  ////////////////////////////////////////////////////////////

  logic            flush_dly;
  logic            req_acc;
  // low pc bits of each request still on the bus
  logic [1:0]      mq [MAX_OUTSTANDING];
  logic [1:0]      mq_cnt;
  logic            mq_wr;
  // parcel queue, entry 0 is the head
  parcel_t         q [3];
  parcel_t         q_nxt [3];
  logic [2:0]      q_vld;
  logic [2:0]      q_vld_nxt;
  parcel_t         wr_ent;
  logic            q_rd;

  ////////////////////////////////////////////////////////////
  // request side
  ////////////////////////////////////////////////////////////

  // no issue while dcache flushes, on flush, on stall or queue half full
  assign biu_req.stb = dc_flush_rdy & ~flush & ~stall & ~q_vld[1];
  // always word aligned, offset kept locally
  assign biu_req.adr = {nxt_pc[XLEN-1:2], 2'b00};
  assign biu_req.prv = st_prv;

  assign req_acc      = biu_req.stb & stb_ack;
  // pc only advances on an accepted request
  assign stall_nxt_pc = ~req_acc;

  // flush also masks the cycle after it
  always_ff @(posedge clk or negedge rstn) begin
    if (!rstn) begin
      flush_dly <= 1'b0;
    end else begin
      flush_dly <= flush;
    end
  end

  ////////////////////////////////////////////////////////////
  // in-flight offset queue
  ////////////////////////////////////////////////////////////

  // slot for a push, after a same-cycle pop
  assign mq_wr = mq_cnt[1] | (mq_cnt[0] & ~biu_rsp.rack);

  always_ff @(posedge clk or negedge rstn) begin
    if (!rstn) begin
      mq_cnt <= 2'd0;
    end else if (flush) begin
      // killed reads never return a rack
      mq_cnt <= 2'd0;
    end else begin
      mq_cnt <= mq_cnt + {1'b0, req_acc} - {1'b0, biu_rsp.rack};
    end
  end

  always_ff @(posedge clk) begin
    if (biu_rsp.rack) begin
      mq[0] <= mq[1];
    end
    if (req_acc) begin
      mq[mq_wr] <= nxt_pc[1:0];
    end
  end

  ////////////////////////////////////////////////////////////
  // parcel queue
  ////////////////////////////////////////////////////////////

  // returned word with the original pc restored
  assign wr_ent.valid      = biu_rsp.rack;
  assign wr_ent.pc         = {biu_rsp.adr[XLEN-1:2], mq[0]};
  assign wr_ent.insn       = biu_rsp.dat;
  assign wr_ent.misaligned = |mq[0];
  assign wr_ent.err        = biu_rsp.err;

  assign q_rd = parcel.valid;

  // shift on read, then fill first free slot
  always_comb begin
    q_vld_nxt = q_vld;
    q_nxt     = q;
    if (q_rd) begin
      q_vld_nxt = {1'b0, q_vld[2:1]};
      q_nxt[0]  = q[1];
      q_nxt[1]  = q[2];
    end
    if (biu_rsp.rack) begin
      if (!q_vld_nxt[0]) begin
        q_vld_nxt[0] = 1'b1;
        q_nxt[0]     = wr_ent;
      end else if (!q_vld_nxt[1]) begin
        q_vld_nxt[1] = 1'b1;
        q_nxt[1]     = wr_ent;
      end else begin
        q_vld_nxt[2] = 1'b1;
        q_nxt[2]     = wr_ent;
      end
    end
    // old path gone at the next edge
    if (flush) begin
      q_vld_nxt = 3'b000;
    end
  end

  always_ff @(posedge clk or negedge rstn) begin
    if (!rstn) begin
      q_vld <= 3'b000;
    end else begin
      q_vld <= q_vld_nxt;
    end
  end

  always_ff @(posedge clk) begin
    q <= q_nxt;
  end

  ////////////////////////////////////////////////////////////
  // to decode
  ////////////////////////////////////////////////////////////

  always_comb begin
    parcel       = q[0];
    parcel.valid = q_vld[0] & ~stall & ~(flush | flush_dly);
  end

endmodule

`default_nettype wire

//--- hw/fetch_pc_gen.sv
`timescale 1ns/10ps
`default_nettype none

module fetch_pc_gen import fetch_pkg::*; (
  input  logic            clk,
  input  logic            rstn,
  // redirect request from the core
  input  redirect_t       redirect,
  // fetch unit could not take the current pc
  input  logic            stall_nxt_pc,
  // address of the next fetch
  output logic [XLEN-1:0] nxt_pc,
  // kills the old path for one cycle
  output logic            flush
);

  ////////////////////////////////////////////////////////////
  // next pc
  ////////////////////////////////////////////////////////////

  // sequential successor, one word ahead
  logic [XLEN-1:0] pc_seq;

  assign pc_seq = nxt_pc + XLEN'(4);

  // redirect wins over sequential advance
  // pc only moves once the fetch unit took the request
  always_ff @(posedge clk or negedge rstn) begin
    if (!rstn) begin
      nxt_pc <= RESET_PC;
    end else if (redirect.valid) begin
      nxt_pc <= redirect.target;
    end else if (!stall_nxt_pc) begin
      nxt_pc <= pc_seq;
    end
  end

  ////////////////////////////////////////////////////////////
  // flush
  ////////////////////////////////////////////////////////////

  // high in the cycle where pc holds the redirect target
  // anything fetched before that belongs to the old path
  always_ff @(posedge clk or negedge rstn) begin
    if (!rstn) begin
      flush <= 1'b0;
    end else begin
      // one cycle per redirect
      flush <= redirect.valid;
    end
  end

endmodule

`default_nettype wire

//--- hw/fetch_pkg.sv
`default_nettype none

package fetch_pkg;

  ////////////////////////////////////////////////////////////
  // widths and constants
  ////////////////////////////////////////////////////////////

  // data and address width
  localparam int XLEN = 32;

  // first fetch address out of reset
  localparam logic [XLEN-1:0] RESET_PC = 32'h0000_0100;

  // reads the bus interface may have in flight
  localparam int MAX_OUTSTANDING = 2;

  ////////////////////////////////////////////////////////////
  // enums
  ////////////////////////////////////////////////////////////

  // privilege level, encoded as in mstatus
  typedef enum logic [1:0] {
    PRV_U = 2'b00,
    PRV_S = 2'b01,
    PRV_M = 2'b11
  } prv_e;

  // bus interface request state
  typedef enum logic {
    BIU_IDLE = 1'b0,
    BIU_AR   = 1'b1
  } biu_state_e;

  // AXI read response codes
  typedef enum logic [1:0] {
    RESP_OKAY   = 2'b00,
    RESP_EXOKAY = 2'b01,
    RESP_SLVERR = 2'b10,
    RESP_DECERR = 2'b11
  } axil_resp_e;

  ////////////////////////////////////////////////////////////
  // bundles
  ////////////////////////////////////////////////////////////

  // branch/exception redirect from the core
  typedef struct packed {
    logic            valid;
    logic [XLEN-1:0] target;
  } redirect_t;

  // instruction parcel handed to decode
  typedef struct packed {
    logic            valid;
    logic [XLEN-1:0] pc;
    logic [XLEN-1:0] insn;
    logic            misaligned;
    logic            err;
  } parcel_t;

  // fetch unit to BIU request
  typedef struct packed {
    logic            stb;
    logic [XLEN-1:0] adr;
    prv_e            prv;
  } biu_req_t;

  // BIU to fetch unit response
  typedef struct packed {
    logic            rack;
    logic [XLEN-1:0] adr;
    logic [XLEN-1:0] dat;
    logic            err;
  } biu_rsp_t;

  // AXI4-Lite read address channel, master driven part
  // arprot[2] instruction, arprot[0] privileged
  typedef struct packed {
    logic            arvalid;
    logic [XLEN-1:0] araddr;
    logic [2:0]      arprot;
  } axil_ar_t;

  // AXI4-Lite read data channel, slave driven part
  typedef struct packed {
    logic            rvalid;
    logic [XLEN-1:0] rdata;
    axil_resp_e      rresp;
  } axil_r_t;

endpackage

`default_nettype wire
